//--- hdl/audio_ctrl_consts.svh
// Shared command, output-type and error codes plus field widths; include wherever they are needed
`ifndef AUDIO_CTRL_CONSTS_SVH
`define AUDIO_CTRL_CONSTS_SVH

// ======================================
// Field widths
// ======================================
// Command byte is {code, payload length}
`define AUDIO_CMD_WIDTH   2
`define AUDIO_LEN_WIDTH   6
`define AUDIO_BYTE_WIDTH  8

// Setup payload fields, packed as {type, channels, rate, depth}
`define AUDIO_IO_TYPE_WIDTH  2
`define AUDIO_RATE_WIDTH     3
`define AUDIO_DEPTH_WIDTH    2

// ======================================
// Command codes
// ======================================
`define CMD_SETUP_OUTPUT   2'd0
`define CMD_SETUP_INPUT    2'd1
`define CMD_STREAM_OUTPUT  2'd2
`define CMD_STOP           2'd3
// Header code of the reply sent back to the host
`define CMD_STOPPED        2'd3
// Payload length carried in the reply header
`define STOPPED_REPLY_LEN  6'd1

// Output types
`define IO_TYPE_AES3     2'd0
`define IO_TYPE_BNC      2'd1
`define IO_TYPE_TOSLINK  2'd2
`define IO_TYPE_I2S      2'd3

// Error codes, one byte each
`define ERROR_NONE                          8'h00
`define ERROR_INVALID_SETUP_OUTPUT_PAYLOAD  8'h01
`define ERROR_INVALID_STOP_PAYLOAD          8'h02

`endif

//--- hdl/audio_ctrl_pkg.sv
// Struct types shared by the controller blocks; compile before any module that refers to them
`default_nettype none

`include "audio_ctrl_consts.svh"

package audio_ctrl_pkg;

    // ======================================
    // Output configuration
    // ======================================
    // Upper eight bits follow the setup payload byte layout
    // so a payload byte maps straight onto the fields
    typedef struct packed {
        // Output type code
        logic [`AUDIO_IO_TYPE_WIDTH-1:0] io_type;
        // Channel count selector
        logic                            channels;
        // Sample rate index
        logic [`AUDIO_RATE_WIDTH-1:0]    sample_rate;
        // Bit depth index
        logic [`AUDIO_DEPTH_WIDTH-1:0]   bit_depth;
        // Low until a good setup has been received
        logic                            valid;
    } audio_cfg_t;

    // ======================================
    // Reply request
    // ======================================
    typedef struct packed {
        // One-cycle strobe
        logic                          start;
        // Second reply byte
        logic [`AUDIO_BYTE_WIDTH-1:0]  error_code;
        // Controller stops reading after this reply
        logic                          halt;
    } reply_req_t;

endpackage

`default_nettype wire

//--- hdl/cmd_parser.sv
// Host command parser; reads the input FIFO, splits commands from payloads and holds the config
`timescale 1ns/1ps
`default_nettype none

`include "audio_ctrl_consts.svh"

module cmd_parser (
    input  logic                          clk,
    input  logic                          reset_i,
    // Host input FIFO, first-word-fall-through
    input  logic                          rd_empty_i,
    input  logic [`AUDIO_BYTE_WIDTH-1:0]  rd_data_i,
    output logic                          rd_en_o,
    // Flow control
    input  logic                          sink_ready_i,
    input  logic                          writer_busy_i,
    // Configuration, reply request and sample stream
    output audio_ctrl_pkg::audio_cfg_t    cfg_o,
    output audio_ctrl_pkg::reply_req_t    reply_o,
    output logic [`AUDIO_BYTE_WIDTH-1:0]  sample_o,
    output logic                          sample_stb_o,
    // Sticky error, also the halt flag
    output logic                          err_o
);

    localparam logic ST_CMD     = 1'b0;
    localparam logic ST_PAYLOAD = 1'b1;
    localparam logic [`AUDIO_LEN_WIDTH-1:0] LEN_ONE = 1;

    logic                         state_q;
    logic [`AUDIO_CMD_WIDTH-1:0]  cmd_q;
    logic [`AUDIO_LEN_WIDTH-1:0]  remaining_q;
    logic [`AUDIO_CMD_WIDTH-1:0]  head_cmd;
    logic [`AUDIO_LEN_WIDTH-1:0]  head_len;
    logic                         in_stream;
    logic                         consume;
    logic                         is_cmd;
    logic                         bad_setup;
    logic                         bad_stop;

    // ======================================
    // Head byte decode
    // ======================================
    assign head_cmd = rd_data_i[`AUDIO_BYTE_WIDTH-1 -: `AUDIO_CMD_WIDTH];
    assign head_len = rd_data_i[`AUDIO_LEN_WIDTH-1:0];

    // Stream payload byte waiting at the FIFO head
    assign in_stream = (state_q == ST_PAYLOAD) && (cmd_q == `CMD_STREAM_OUTPUT);

    // Stall while a reply is going out, once halted, or when the sink cannot take the byte
    assign rd_en_o = !rd_empty_i && !writer_busy_i && !err_o && !(in_stream && !sink_ready_i);
    assign consume = rd_en_o;
    assign is_cmd  = consume && (state_q == ST_CMD);

    // Setup wants exactly one payload byte, stop wants none
    assign bad_setup = is_cmd && (head_cmd == `CMD_SETUP_OUTPUT) && (head_len != LEN_ONE);
    assign bad_stop  = is_cmd && (head_cmd == `CMD_STOP) && (head_len != '0);

    // Reply goes out in the same cycle as the command so busy rises at that edge
    always_comb begin
        reply_o.start = (is_cmd && head_cmd == `CMD_STOP) || bad_setup;
        reply_o.halt  = bad_setup || bad_stop;
        if (bad_setup) begin
            reply_o.error_code = `ERROR_INVALID_SETUP_OUTPUT_PAYLOAD;
        end else if (bad_stop) begin
            reply_o.error_code = `ERROR_INVALID_STOP_PAYLOAD;
        end else begin
            reply_o.error_code = `ERROR_NONE;
        end
    end

    // ======================================
    // Command / payload FSM
    // ======================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q      <= ST_CMD;
            cmd_q        <= '0;
            remaining_q  <= '0;
            cfg_o        <= '0;
            sample_stb_o <= 1'b0;
            err_o        <= 1'b0;
        end else begin
            sample_stb_o <= 1'b0;
            // Malformed command halts until reset
            if (reply_o.start && reply_o.halt) begin
                err_o <= 1'b1;
            end
            if (is_cmd) begin
                // A halting command never enters its payload
                if (!reply_o.halt && head_len != '0) begin
                    state_q     <= ST_PAYLOAD;
                    cmd_q       <= head_cmd;
                    remaining_q <= head_len;
                end
            end else if (consume) begin
                remaining_q <= remaining_q - LEN_ONE;
                if (remaining_q == LEN_ONE) begin
                    state_q <= ST_CMD;
                end
                case (cmd_q)
                    // Payload byte layout equals the upper config fields
                    `CMD_SETUP_OUTPUT: cfg_o <= audio_ctrl_pkg::audio_cfg_t'({rd_data_i, 1'b1});
                    `CMD_STREAM_OUTPUT: sample_stb_o <= 1'b1;
                    // Input setup is not supported, bytes are dropped
                    `CMD_SETUP_INPUT: ;
                    default: ;
                endcase
            end
        end
    end

    // Sample byte register
    always_ff @(posedge clk) begin
        if (consume && in_stream) begin
            sample_o <= rd_data_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/status_writer.sv
// Reply writer; buffers the two stopped-reply bytes and pushes them into the host output FIFO
`timescale 1ns/1ps
`default_nettype none

`include "audio_ctrl_consts.svh"

module status_writer (
    input  logic                          clk,
    input  logic                          reset_i,
    // Request from the parser
    input  audio_ctrl_pkg::reply_req_t    reply_i,
    // Host output FIFO
    input  logic                          out_full_i,
    output logic                          out_wr_en_o,
    output logic [`AUDIO_BYTE_WIDTH-1:0]  out_data_o,
    // High from request until the last byte is out
    output logic                          busy_o
);

    localparam logic [`AUDIO_LEN_WIDTH-1:0] LEN_ONE = 1;

    // Byte 0 is the header, byte 1 the error code
    logic [`AUDIO_BYTE_WIDTH-1:0]  reply_buf [2];
    logic [`AUDIO_LEN_WIDTH-1:0]   idx_q;
    logic [`AUDIO_LEN_WIDTH-1:0]   last_idx;
    logic                          send;

    // Header plus its payload length
    assign last_idx = reply_buf[0][`AUDIO_LEN_WIDTH-1:0] + LEN_ONE;

    // out_full_i is sampled at the edge, so a write only follows a not-full cycle
    assign send = busy_o && !reply_i.start && (idx_q != last_idx) && !out_full_i;

    // Reply bytes
    always_ff @(posedge clk) begin
        if (reply_i.start) begin
            reply_buf[0] <= {`CMD_STOPPED, `STOPPED_REPLY_LEN};
            reply_buf[1] <= reply_i.error_code;
        end
        if (send) begin
            out_data_o <= reply_buf[idx_q[0]];
        end
    end

    // ======================================
    // Write sequencer
    // ======================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            busy_o      <= 1'b0;
            idx_q       <= '0;
            out_wr_en_o <= 1'b0;
        end else begin
            out_wr_en_o <= send;
            if (reply_i.start) begin
                busy_o <= 1'b1;
                idx_q  <= '0;
            end else if (busy_o) begin
                if (idx_q == last_idx) begin
                    // All bytes written
                    busy_o <= 1'b0;
                end else if (send) begin
                    idx_q <= idx_q + LEN_ONE;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/sample_router.sv
// Sample router; picks the sink from the output type and registers byte writes to it
`timescale 1ns/1ps
`default_nettype none

`include "audio_ctrl_consts.svh"

module sample_router (
    input  logic                          clk,
    input  logic                          reset_i,
    input  audio_ctrl_pkg::audio_cfg_t    cfg_i,
    // Sample stream from the parser
    input  logic [`AUDIO_BYTE_WIDTH-1:0]  sample_i,
    input  logic                          sample_stb_i,
    // Sink levels, almost-full already merged
    input  logic                          spdif_full_i,
    input  logic                          i2s_full_i,
    output logic                          sink_ready_o,
    // Sink write port
    output logic [`AUDIO_BYTE_WIDTH-1:0]  sample_o,
    output logic                          spdif_wr_en_o,
    output logic                          i2s_wr_en_o
);

    logic sel_spdif;
    logic sel_i2s;

    // All coax and optical types share the S/PDIF sink
    always_comb begin
        sel_spdif = 1'b0;
        sel_i2s   = 1'b0;
        if (cfg_i.valid) begin
            case (cfg_i.io_type)
                `IO_TYPE_AES3, `IO_TYPE_BNC, `IO_TYPE_TOSLINK: sel_spdif = 1'b1;
                `IO_TYPE_I2S: sel_i2s = 1'b1;
                default: ;
            endcase
        end
    end

    // Unconfigured: bytes are taken and thrown away
    assign sink_ready_o = !cfg_i.valid || (sel_spdif && !spdif_full_i) || (sel_i2s && !i2s_full_i);

    // Data register
    always_ff @(posedge clk) begin
        if (sample_stb_i) begin
            sample_o <= sample_i;
        end
    end

    // Write enables, only the selected sink
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            spdif_wr_en_o <= 1'b0;
            i2s_wr_en_o   <= 1'b0;
        end else begin
            spdif_wr_en_o <= sample_stb_i && sel_spdif;
            i2s_wr_en_o   <= sample_stb_i && sel_i2s;
        end
    end

endmodule

`default_nettype wire

//--- hdl/audio_ctrl_top.sv
// Top level of the USB audio bridge controller; connects parser, reply writer and sample router
`timescale 1ns/1ps
`default_nettype none

`include "audio_ctrl_consts.svh"

module audio_ctrl_top (
    input  logic                          clk,
    input  logic                          reset_i,
    // Host input FIFO
    input  logic                          rd_empty_i,
    input  logic [`AUDIO_BYTE_WIDTH-1:0]  rd_data_i,
    output logic                          rd_en_o,
    // Host output FIFO
    input  logic                          out_full_i,
    output logic                          out_wr_en_o,
    output logic [`AUDIO_BYTE_WIDTH-1:0]  out_data_o,
    // External sinks
    input  logic                          spdif_full_i,
    input  logic                          i2s_full_i,
    output logic [`AUDIO_BYTE_WIDTH-1:0]  sample_o,
    output logic                          spdif_wr_en_o,
    output logic                          i2s_wr_en_o,
    // Error level
    output logic                          err_o
);

    audio_ctrl_pkg::audio_cfg_t    cfg;
    audio_ctrl_pkg::reply_req_t    reply;
    logic [`AUDIO_BYTE_WIDTH-1:0]  parsed_sample;
    logic                          parsed_stb;
    logic                          writer_busy;
    logic                          sink_ready;

    // ======================================
    // Blocks
    // ======================================
    cmd_parser u_parser (
        .clk           (clk),
        .reset_i       (reset_i),
        .rd_empty_i    (rd_empty_i),
        .rd_data_i     (rd_data_i),
        .rd_en_o       (rd_en_o),
        .sink_ready_i  (sink_ready),
        .writer_busy_i (writer_busy),
        .cfg_o         (cfg),
        .reply_o       (reply),
        .sample_o      (parsed_sample),
        .sample_stb_o  (parsed_stb),
        .err_o         (err_o)
    );

    status_writer u_writer (
        .clk         (clk),
        .reset_i     (reset_i),
        .reply_i     (reply),
        .out_full_i  (out_full_i),
        .out_wr_en_o (out_wr_en_o),
        .out_data_o  (out_data_o),
        .busy_o      (writer_busy)
    );

    sample_router u_router (
        .clk           (clk),
        .reset_i       (reset_i),
        .cfg_i         (cfg),
        .sample_i      (parsed_sample),
        .sample_stb_i  (parsed_stb),
        .spdif_full_i  (spdif_full_i),
        .i2s_full_i    (i2s_full_i),
        .sink_ready_o  (sink_ready),
        .sample_o      (sample_o),
        .spdif_wr_en_o (spdif_wr_en_o),
        .i2s_wr_en_o   (i2s_wr_en_o)
    );

endmodule

`default_nettype wire

//--- testbench/audio_ctrl_asserts.sv
// Interface assertions for the controller top level; attached to it by the bind at the end
`timescale 1ns/1ps
`default_nettype none

module audio_ctrl_asserts (
    input logic clk,
    input logic reset_i,
    input logic rd_empty_i,
    input logic rd_en_o,
    input logic out_full_i,
    input logic out_wr_en_o,
    input logic spdif_wr_en_o,
    input logic i2s_wr_en_o
);

    // Failed assertions so far, summed into the testbench totals
    int fail_count = 0;

    // ========================================
    // Host FIFOs
    // ========================================
    read_when_empty: assert property (@(posedge clk) disable iff (reset_i)
        !(rd_en_o && rd_empty_i))
    else begin
        fail_count++;
        $error("rd_en_o high while the input FIFO is empty");
    end

    // A write needs a not-full cycle right before it
    write_after_full: assert property (@(posedge clk) disable iff (reset_i)
        out_wr_en_o |-> !$past(out_full_i))
    else begin
        fail_count++;
        $error("out_wr_en_o high after a cycle with out_full_i high");
    end

    // Only one sink at a time
    one_sink: assert property (@(posedge clk) disable iff (reset_i)
        !(spdif_wr_en_o && i2s_wr_en_o))
    else begin
        fail_count++;
        $error("S/PDIF and I2S write enables high together");
    end

endmodule

bind audio_ctrl_top audio_ctrl_asserts u_asserts (
    .clk           (clk),
    .reset_i       (reset_i),
    .rd_empty_i    (rd_empty_i),
    .rd_en_o       (rd_en_o),
    .out_full_i    (out_full_i),
    .out_wr_en_o   (out_wr_en_o),
    .spdif_wr_en_o (spdif_wr_en_o),
    .i2s_wr_en_o   (i2s_wr_en_o)
);

`default_nettype wire

//--- testbench/audio_ctrl_tb.sv
// Testbench for the audio controller top level; run it as the simulation top with the RTL
`timescale 1ns/1ps
`default_nettype none

`include "audio_ctrl_consts.svh"

module audio_ctrl_tb;

    typedef logic [7:0] byte_q_t[$];

    // Stopped reply header, code 3 with a one-byte payload
    localparam logic [7:0] STOPPED_HDR = 8'hC1;

    logic        clk = 1'b0;
    logic        reset_i;
    logic        rd_empty_i;
    logic [7:0]  rd_data_i;
    logic        rd_en_o;
    logic        out_full_i;
    logic        out_wr_en_o;
    logic [7:0]  out_data_o;
    logic        spdif_full_i;
    logic        i2s_full_i;
    logic [7:0]  sample_o;
    logic        spdif_wr_en_o;
    logic        i2s_wr_en_o;
    logic        err_o;

    logic [31:0] lfsr = 32'hf815;
    // Host FIFO contents, stimulus per phase and expected writes
    byte_q_t     host_q;
    byte_q_t     stim_a;
    byte_q_t     stim_b;
    byte_q_t     exp_spdif;
    byte_q_t     exp_i2s;
    byte_q_t     exp_out;
    // Sink full levels of the last two edges
    // A stream byte read at one edge is written two edges later
    logic [1:0]  spdif_full_hist = 2'b00;
    logic [1:0]  i2s_full_hist = 2'b00;
    int          cycles = 0;
    int          limit = 1000;
    int          mismatches = 0;
    int          failures = 0;

    audio_ctrl_top uut (.*);

    always #2 clk = ~clk;

    // ========================================
    // Random source
    // ========================================
    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic rand_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = rand_bit();
        end
        return b;
    endfunction

    // Command byte followed by len random payload bytes
    // Setup payloads carry io_type in the top bits
    task automatic push_cmd(ref byte_q_t q, input logic [1:0] code, input int len,
                            input logic [1:0] io_type);
        logic [7:0] b;
        q.push_back({code, 6'(len)});
        for (int i = 0; i < len; i++) begin
            b = rand_byte();
            if (code == `CMD_SETUP_OUTPUT) begin
                b[7:6] = io_type;
            end
            q.push_back(b);
        end
    endtask

    // ========================================
    // Reference model
    // ========================================
    // Expected writes for a stream starting from reset
    // Returns the final err level and the count of unread bytes
    function automatic logic model_commands(input byte_q_t cmds, output int left);
        logic       valid = 1'b0;
        logic [1:0] io_type = 2'd0;
        logic [1:0] code;
        int         i = 0;
        int         n;
        left = 0;
        while (i < cmds.size()) begin
            code = cmds[i][7:6];
            n = int'(cmds[i][5:0]);
            i++;
            // Bad length halts and leaves the payload in the FIFO
            if ((code == `CMD_SETUP_OUTPUT && n != 1) || (code == `CMD_STOP && n != 0)) begin
                exp_out.push_back(STOPPED_HDR);
                exp_out.push_back(code == `CMD_STOP ? `ERROR_INVALID_STOP_PAYLOAD
                                                    : `ERROR_INVALID_SETUP_OUTPUT_PAYLOAD);
                left = cmds.size() - i;
                return 1'b1;
            end
            if (code == `CMD_STOP) begin
                exp_out.push_back(STOPPED_HDR);
                exp_out.push_back(`ERROR_NONE);
            end
            for (int k = 0; k < n; k++) begin
                if (code == `CMD_SETUP_OUTPUT) begin
                    valid = 1'b1;
                    io_type = cmds[i][7:6];
                end else if (code == `CMD_STREAM_OUTPUT && valid) begin
                    // I2S has its own sink and every other type goes to S/PDIF
                    if (io_type == `IO_TYPE_I2S) begin
                        exp_i2s.push_back(cmds[i]);
                    end else begin
                        exp_spdif.push_back(cmds[i]);
                    end
                end
                i++;
            end
        end
        return 1'b0;
    endfunction

    task automatic compare_write(ref byte_q_t exp_q, input logic [7:0] got, input string what);
        logic [7:0] want;
        if (exp_q.size() == 0) begin
            $display("Unexpected %s write of %h at %0t", what, got, $time);
            failures++;
        end else begin
            want = exp_q.pop_front();
            if (got !== want) begin
                $display("Mismatch at %0t: %s byte %h, expected %h", $time, what, got, want);
                mismatches++;
            end
        end
    endtask

    // ========================================
    // Host and sink models
    // ========================================
    // FWFT head and random full levels change on the falling edge
    always @(negedge clk) begin
        rd_empty_i   = (host_q.size() == 0);
        rd_data_i    = rd_empty_i ? 8'h00 : host_q[0];
        out_full_i   = rand_bit() & rand_bit();
        spdif_full_i = rand_bit() & rand_bit();
        i2s_full_i   = rand_bit() & rand_bit();
    end

    // Pre-edge values are sampled here
    always @(posedge clk) begin
        cycles++;
        if (!reset_i) begin
            if (rd_en_o && !rd_empty_i) begin
                void'(host_q.pop_front());
            end
            if (spdif_wr_en_o) begin
                compare_write(exp_spdif, sample_o, "S/PDIF");
                if (spdif_full_hist[1]) begin
                    $display("S/PDIF byte was read while the sink was full at %0t", $time);
                    failures++;
                end
            end
            if (i2s_wr_en_o) begin
                compare_write(exp_i2s, sample_o, "I2S");
                if (i2s_full_hist[1]) begin
                    $display("I2S byte was read while the sink was full at %0t", $time);
                    failures++;
                end
            end
            if (out_wr_en_o) begin
                compare_write(exp_out, out_data_o, "reply");
            end
        end
        spdif_full_hist = {spdif_full_hist[0], spdif_full_i};
        i2s_full_hist   = {i2s_full_hist[0], i2s_full_i};
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // Reset, load one stream, wait until every write is seen and the DUT halts
    task automatic run_phase(input byte_q_t cmds);
        int   left;
        logic want_err;
        reset_i = 1'b1;
        want_err = model_commands(cmds, left);
        host_q = cmds;
        repeat (2) @(negedge clk);
        reset_i = 1'b0;
        while (err_o !== want_err || exp_spdif.size() != 0 || exp_i2s.size() != 0 ||
               exp_out.size() != 0 || host_q.size() > left) begin
            @(negedge clk);
        end
        // Halted DUT must stay quiet
        repeat (20) @(negedge clk);
        if (host_q.size() != left) begin
            $display("Mismatch at %0t: %0d input bytes left, expected %0d",
                     $time, host_q.size(), left);
            mismatches++;
        end
        if (err_o !== want_err) begin
            $display("Mismatch at %0t: err_o %b, expected %b", $time, err_o, want_err);
            mismatches++;
        end
    endtask

    initial begin
        reset_i      = 1'b1;
        rd_empty_i   = 1'b1;
        rd_data_i    = 8'h00;
        out_full_i   = 1'b0;
        spdif_full_i = 1'b0;
        i2s_full_i   = 1'b0;
        // Unconfigured stream, TOSLINK, I2S, stop, ignored input setup, bad setup
        push_cmd(stim_a, `CMD_STREAM_OUTPUT, 4, 2'd0);
        push_cmd(stim_a, `CMD_SETUP_OUTPUT, 1, `IO_TYPE_TOSLINK);
        push_cmd(stim_a, `CMD_STREAM_OUTPUT, 24, 2'd0);
        push_cmd(stim_a, `CMD_SETUP_OUTPUT, 1, `IO_TYPE_I2S);
        push_cmd(stim_a, `CMD_STREAM_OUTPUT, 24, 2'd0);
        push_cmd(stim_a, `CMD_STOP, 0, 2'd0);
        push_cmd(stim_a, `CMD_SETUP_INPUT, 2, 2'd0);
        push_cmd(stim_a, `CMD_STREAM_OUTPUT, 8, 2'd0);
        push_cmd(stim_a, `CMD_SETUP_OUTPUT, 2, 2'd0);
        push_cmd(stim_a, `CMD_STREAM_OUTPUT, 4, 2'd0);
        // Stop with a payload after a fresh reset
        push_cmd(stim_b, `CMD_STOP, 3, 2'd0);
        limit = 4 * (stim_a.size() + stim_b.size()) + 200;
        run_phase(stim_a);
        run_phase(stim_b);
        failures += uut.u_asserts.fail_count;
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/audio_ctrl_pkg.sv
hdl/cmd_parser.sv
hdl/status_writer.sv
hdl/sample_router.sv
hdl/audio_ctrl_top.sv
testbench/audio_ctrl_asserts.sv
testbench/audio_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the audio controller testbench
VERILATOR ?= verilator
TOP       ?= audio_ctrl_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
